//--- swu_geom_pkg.sv
`default_nettype none

package swu_geom_pkg;

   //////////////////////////////
   // input feature map
   //////////////////////////////
   localparam int IFM_WIDTH    = 5;
   localparam int IFM_HEIGHT   = 5;
   localparam int IFM_CHANNELS = 4;
   localparam int SIMD         = 2;
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD;

   //////////////////////////////
   // kernel and output map
   //////////////////////////////
   localparam int KERNEL_DIM = 3;
   localparam int OFM_DIM    = IFM_WIDTH - KERNEL_DIM + 1;

   // words per frame and per window
   localparam int FRAME_WORDS  = IFM_HEIGHT * IFM_WIDTH * EFF_CHANNELS;
   localparam int WINDOW_WORDS = KERNEL_DIM * KERNEL_DIM * EFF_CHANNELS;
   localparam int ROW_WORDS    = IFM_WIDTH * EFF_CHANNELS;
   localparam int BUFFER_DEPTH = 32;

   typedef logic [$clog2(FRAME_WORDS)-1:0]  index_t;
   typedef logic [$clog2(BUFFER_DEPTH)-1:0] buf_addr_t;
   typedef logic [$clog2(KERNEL_DIM)-1:0]   kpos_t;
   typedef logic [$clog2(OFM_DIM)-1:0]      opos_t;
   typedef logic [$clog2(EFF_CHANNELS)-1:0] chgrp_t;

   // absolute index to circular buffer address
   // the write-side space rule keeps one subtraction enough
   function automatic buf_addr_t to_buf_addr(input index_t idx);
      if (int'(idx) >= BUFFER_DEPTH) begin
         return buf_addr_t'(int'(idx) - BUFFER_DEPTH);
      end
      return buf_addr_t'(idx);
   endfunction

endpackage

`default_nettype wire

//--- swu_stream_pkg.sv
`default_nettype none

package swu_stream_pkg;

   localparam int PRECISION = 4;

   // one channel group, SIMD lanes of PRECISION bits
   typedef logic [swu_geom_pkg::SIMD-1:0][PRECISION-1:0] swu_word_t;

   //////////////////////////////
   // write port into the buffer
   //////////////////////////////
   typedef struct packed {
      logic                    we;
      swu_geom_pkg::buf_addr_t addr;
      swu_word_t               data;
   } swu_wr_port_t;

   //////////////////////////////
   // read request to the buffer
   //////////////////////////////
   typedef struct packed {
      logic                    valid;
      swu_geom_pkg::buf_addr_t addr;
      // final word of the frame
      logic                    last;
   } swu_rd_req_t;

endpackage

`default_nettype wire

//--- swu_write_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module swu_write_ctrl (
   input  wire logic                         clk,
   input  wire logic                         resetn,
   input  wire logic                         in_valid_i,
   input  wire swu_stream_pkg::swu_word_t    in_data_i,
   input  wire swu_geom_pkg::index_t         window_base_i,
   input  wire logic                         frame_done_i,
   output logic                              in_ready_o,
   output swu_stream_pkg::swu_wr_port_t      wr_port_o,
   output swu_geom_pkg::index_t              words_written_o
);

   import swu_geom_pkg::*;

   index_t wr_count;
   logic   frame_open;
   logic   room_ok;
   logic   wr_fire;

   //////////////////////////////
   // acceptance
   //////////////////////////////

   // stop at the end of the frame
   assign frame_open = int'(wr_count) < FRAME_WORDS;

   // words below window_base are no longer needed by any window
   assign room_ok = int'(wr_count) < int'(window_base_i) + BUFFER_DEPTH;

   assign in_ready_o = frame_open && room_ok;
   assign wr_fire    = in_valid_i && in_ready_o;

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_count <= '0;
      end else if (wr_fire) begin
         wr_count <= index_t'(wr_count + 1'b1);
      end
   end

   //////////////////////////////
   // write port
   //////////////////////////////
   always_comb begin
      wr_port_o.we   = wr_fire;
      wr_port_o.addr = to_buf_addr(wr_count);
      wr_port_o.data = in_data_i;
   end

   assign words_written_o = wr_count;

endmodule

`default_nettype wire

//--- swu_read_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module swu_read_ctrl (
   input  wire logic                    clk,
   input  wire logic                    resetn,
   input  wire swu_geom_pkg::index_t    words_written_i,
   input  wire logic                    rd_ready_i,
   input  wire logic                    frame_done_i,
   output swu_stream_pkg::swu_rd_req_t  rd_req_o,
   output swu_geom_pkg::index_t         window_base_o
);

   import swu_geom_pkg::*;

   opos_t  orow;
   opos_t  ocol;
   kpos_t  kh;
   kpos_t  kw;
   chgrp_t grp;
   logic   all_issued;

   index_t window_base;
   index_t need_idx;
   logic   last_grp;
   logic   last_kw;
   logic   last_kh;
   logic   last_ocol;
   logic   last_orow;
   logic   last_req;
   logic   issue;

   //////////////////////////////
   // addressing
   //////////////////////////////

   // stride 1, one output pixel per window
   assign window_base = index_t'(int'(orow) * ROW_WORDS + int'(ocol) * EFF_CHANNELS);

   assign need_idx = index_t'(int'(window_base) + int'(kh) * ROW_WORDS
                              + int'(kw) * EFF_CHANNELS + int'(grp));

   assign last_grp  = grp == chgrp_t'(EFF_CHANNELS - 1);
   assign last_kw   = kw == kpos_t'(KERNEL_DIM - 1);
   assign last_kh   = kh == kpos_t'(KERNEL_DIM - 1);
   assign last_ocol = ocol == opos_t'(OFM_DIM - 1);
   assign last_orow = orow == opos_t'(OFM_DIM - 1);
   assign last_req  = last_grp && last_kw && last_kh && last_ocol && last_orow;

   // word must have arrived and the pipeline must have room
   assign issue = (need_idx < words_written_i) && rd_ready_i && !all_issued;

   always_comb begin
      rd_req_o.valid = issue;
      rd_req_o.addr  = to_buf_addr(need_idx);
      rd_req_o.last  = last_req;
   end

   assign window_base_o = window_base;

   //////////////////////////////
   // window counters
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         orow       <= '0;
         ocol       <= '0;
         kh         <= '0;
         kw         <= '0;
         grp        <= '0;
         all_issued <= 1'b0;
      end else if (issue) begin
         if (last_req) begin
            // hold until the last word leaves the buffer
            all_issued <= 1'b1;
         end else if (!last_grp) begin
            grp <= chgrp_t'(grp + 1'b1);
         end else begin
            grp <= '0;
            if (!last_kw) begin
               kw <= kpos_t'(kw + 1'b1);
            end else begin
               kw <= '0;
               if (!last_kh) begin
                  kh <= kpos_t'(kh + 1'b1);
               end else begin
                  kh <= '0;
                  if (!last_ocol) begin
                     ocol <= opos_t'(ocol + 1'b1);
                  end else begin
                     ocol <= '0;
                     orow <= opos_t'(orow + 1'b1);
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- swu_window_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module swu_window_buffer (
   input  wire logic                          clk,
   input  wire logic                          resetn,
   input  wire swu_stream_pkg::swu_wr_port_t  wr_port_i,
   input  wire swu_stream_pkg::swu_rd_req_t   rd_req_i,
   input  wire logic                          out_ready_i,
   output logic                               rd_ready_o,
   output swu_stream_pkg::swu_word_t          out_data_o,
   output logic                               out_valid_o,
   output logic                               frame_done_o
);

   import swu_geom_pkg::*;
   import swu_stream_pkg::*;

   swu_word_t mem [BUFFER_DEPTH];

   // read stage
   logic      rd_valid;
   logic      rd_last;
   swu_word_t rd_data;

   // output stage
   logic      out_valid;
   logic      out_last;
   swu_word_t out_data;

   logic      advance;

   //////////////////////////////
   // memory write port
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_port_i.we) begin
         mem[wr_port_i.addr] <= wr_port_i.data;
      end
   end

   // output stage empty or taken this cycle
   assign advance    = !out_valid || out_ready_i;
   assign rd_ready_o = advance || !rd_valid;

   //////////////////////////////
   // read pipeline
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid  <= 1'b0;
         rd_last   <= 1'b0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
      end else begin
         if (rd_ready_o) begin
            rd_valid <= rd_req_i.valid;
            rd_last  <= rd_req_i.valid && rd_req_i.last;
         end
         if (advance) begin
            out_valid <= rd_valid;
            out_last  <= rd_last;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_ready_o && rd_req_i.valid) begin
         rd_data <= mem[rd_req_i.addr];
      end
      if (advance && rd_valid) begin
         out_data <= rd_data;
      end
   end

   assign out_data_o  = out_data;
   assign out_valid_o = out_valid;

   // last word of the frame accepted downstream
   assign frame_done_o = out_valid && out_ready_i && out_last;

endmodule

`default_nettype wire

//--- swu_top.sv
`timescale 1ns/10ps
`default_nettype none

module swu_top (
   input  wire logic                       clk,
   input  wire logic                       resetn,
   input  wire swu_stream_pkg::swu_word_t  in_data_i,
   input  wire logic                       in_valid_i,
   input  wire logic                       out_ready_i,
   output logic                            in_ready_o,
   output swu_stream_pkg::swu_word_t       out_data_o,
   output logic                            out_valid_o
);

   import swu_geom_pkg::*;
   import swu_stream_pkg::*;

   swu_wr_port_t wr_port;
   swu_rd_req_t  rd_req;
   index_t       words_written;
   index_t       window_base;
   logic         rd_ready;
   logic         frame_done;

   //////////////////////////////
   // write side
   //////////////////////////////
   swu_write_ctrl u_write_ctrl (
      .clk             (clk),
      .resetn          (resetn),
      .in_valid_i      (in_valid_i),
      .in_data_i       (in_data_i),
      .window_base_i   (window_base),
      .frame_done_i    (frame_done),
      .in_ready_o      (in_ready_o),
      .wr_port_o       (wr_port),
      .words_written_o (words_written)
   );

   //////////////////////////////
   // read side
   //////////////////////////////
   swu_read_ctrl u_read_ctrl (
      .clk             (clk),
      .resetn          (resetn),
      .words_written_i (words_written),
      .rd_ready_i      (rd_ready),
      .frame_done_i    (frame_done),
      .rd_req_o        (rd_req),
      .window_base_o   (window_base)
   );

   // line buffer and output pipeline
   swu_window_buffer u_window_buffer (
      .clk          (clk),
      .resetn       (resetn),
      .wr_port_i    (wr_port),
      .rd_req_i     (rd_req),
      .out_ready_i  (out_ready_i),
      .rd_ready_o   (rd_ready),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .frame_done_o (frame_done)
   );

endmodule

`default_nettype wire

//--- tb_swu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_swu_top;

   import swu_geom_pkg::*;
   import swu_stream_pkg::*;

   localparam int OUT_WORDS   = OFM_DIM * OFM_DIM * WINDOW_WORDS;
   localparam int FRAME_SPAN  = FRAME_WORDS + OUT_WORDS;
   localparam int TOTAL_WORDS = 3 * FRAME_SPAN;
   localparam int CYCLE_LIMIT = 8 * 3 * (FRAME_WORDS + 9 * WINDOW_WORDS) + 100;
   localparam int IDLE_CYCLES = 20;

   logic      clk = 1'b0;
   logic      resetn;
   swu_word_t in_data;
   logic      in_valid;
   logic      in_ready;
   swu_word_t out_data;
   logic      out_valid;
   logic      out_ready;

   logic [$bits(swu_word_t)-1:0] tdata [TOTAL_WORDS];

   int err_count = 0;
   int chk_count = 0;
   int test_count = 0;
   int cycles = 0;

   swu_top uut (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .out_ready_i (out_ready),
      .in_ready_o  (in_ready),
      .out_data_o  (out_data),
      .out_valid_o (out_valid)
   );

   always #2 clk = ~clk;

   //////////////////////////////
   // compare tasks
   //////////////////////////////
   task automatic check_word(input string name, input swu_word_t exp, input swu_word_t act);
      chk_count++;
      if (act !== exp) begin
         err_count++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      chk_count++;
      if (act !== exp) begin
         err_count++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic report_test(input string name, input int chk0, input int err0);
      test_count++;
      $display("%s: %0d checks, %0d errors", name, chk_count - chk0, err_count - err0);
   endtask

   //////////////////////////////
   // stream drivers
   //////////////////////////////

   // valid holds with stable data until ready
   task automatic drive_frame(input int f, input bit gaps, input string name);
      int gap;
      for (int i = 0; i < FRAME_WORDS; i++) begin
         gap = gaps ? int'($urandom % 3) : 0;
         repeat (gap) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
         end
         in_valid = 1'b1;
         in_data  = tdata[f * FRAME_SPAN + i];
         @(negedge clk);
         while (!in_ready) begin
            @(negedge clk);
         end
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      // a full frame holds input off until the restart
      @(negedge clk);
      check_flag({name, " full in_ready"}, 1'b0, in_ready);
   endtask

   task automatic collect_frame(input int f, input bit stall, input string name);
      int j;
      j = 0;
      while (j < OUT_WORDS) begin
         out_ready = stall ? ($urandom % 2 == 1) : 1'b1;
         @(negedge clk);
         if (out_valid && out_ready) begin
            check_word($sformatf("%s word %0d", name, j),
                       tdata[f * FRAME_SPAN + FRAME_WORDS + j], out_data);
            j++;
         end
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_frame(input int f, input bit rnd, input string name);
      int chk0;
      int err0;
      chk0     = chk_count;
      err0     = err_count;
      fork
         drive_frame(f, rnd, name);
         collect_frame(f, rnd, name);
      join
      // nothing more comes out until the next frame starts
      out_ready = 1'b1;
      repeat (IDLE_CYCLES) begin
         @(negedge clk);
         check_flag({name, " idle out_valid"}, 1'b0, out_valid);
      end
      check_flag({name, " restart in_ready"}, 1'b1, in_ready);
      @(posedge clk);
      #1;
      report_test(name, chk0, err0);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      int seed_val;
      int chk0;
      int err0;
      seed_val  = $urandom(61287);
      resetn    = 1'b0;
      in_valid  = 1'b0;
      in_data   = '0;
      out_ready = 1'b0;
      $readmemh("swu_testdata.txt", tdata);
      if ($isunknown(tdata[TOTAL_WORDS-1])) begin
         err_count++;
         $display("data file swu_testdata.txt is missing or too short");
      end
      repeat (16) @(posedge clk);
      #1;
      resetn = 1'b1;
      @(posedge clk);
      #1;
      chk0 = chk_count;
      err0 = err_count;
      @(negedge clk);
      check_flag("reset out_valid", 1'b0, out_valid);
      check_flag("reset in_ready", 1'b1, in_ready);
      @(posedge clk);
      #1;
      report_test("reset_state", chk0, err0);
      run_frame(0, 1'b0, "frame1_stream");
      run_frame(1, 1'b0, "frame2_restart");
      run_frame(2, 1'b1, "frame3_stall");
      $display("%0d tests run, %0d checks, %0d errors", test_count, chk_count, err_count);
      if (err_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: DUT hung, no progress after %0d cycles", cycles);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- swu_testdata.txt
// hex words, three frames; each frame has 5 input rows of 10 words (column, group)
// then 9 output windows of 18 words (kernel row, kernel column, group)
// frame 1
00 01 02 03 04 05 06 07 08 09
0a 0b 0c 0d 0e 0f 10 11 12 13
14 15 16 17 18 19 1a 1b 1c 1d
1e 1f 20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f 30 31
00 01 02 03 04 05 0a 0b 0c 0d 0e 0f 14 15 16 17 18 19
02 03 04 05 06 07 0c 0d 0e 0f 10 11 16 17 18 19 1a 1b
04 05 06 07 08 09 0e 0f 10 11 12 13 18 19 1a 1b 1c 1d
0a 0b 0c 0d 0e 0f 14 15 16 17 18 19 1e 1f 20 21 22 23
0c 0d 0e 0f 10 11 16 17 18 19 1a 1b 20 21 22 23 24 25
0e 0f 10 11 12 13 18 19 1a 1b 1c 1d 22 23 24 25 26 27
14 15 16 17 18 19 1e 1f 20 21 22 23 28 29 2a 2b 2c 2d
16 17 18 19 1a 1b 20 21 22 23 24 25 2a 2b 2c 2d 2e 2f
18 19 1a 1b 1c 1d 22 23 24 25 26 27 2c 2d 2e 2f 30 31
// frame 2
60 61 62 63 64 65 66 67 68 69
6a 6b 6c 6d 6e 6f 70 71 72 73
74 75 76 77 78 79 7a 7b 7c 7d
7e 7f 80 81 82 83 84 85 86 87
88 89 8a 8b 8c 8d 8e 8f 90 91
60 61 62 63 64 65 6a 6b 6c 6d 6e 6f 74 75 76 77 78 79
62 63 64 65 66 67 6c 6d 6e 6f 70 71 76 77 78 79 7a 7b
64 65 66 67 68 69 6e 6f 70 71 72 73 78 79 7a 7b 7c 7d
6a 6b 6c 6d 6e 6f 74 75 76 77 78 79 7e 7f 80 81 82 83
6c 6d 6e 6f 70 71 76 77 78 79 7a 7b 80 81 82 83 84 85
6e 6f 70 71 72 73 78 79 7a 7b 7c 7d 82 83 84 85 86 87
74 75 76 77 78 79 7e 7f 80 81 82 83 88 89 8a 8b 8c 8d
76 77 78 79 7a 7b 80 81 82 83 84 85 8a 8b 8c 8d 8e 8f
78 79 7a 7b 7c 7d 82 83 84 85 86 87 8c 8d 8e 8f 90 91
// frame 3
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9
ca cb cc cd ce cf d0 d1 d2 d3
d4 d5 d6 d7 d8 d9 da db dc dd
de df e0 e1 e2 e3 e4 e5 e6 e7
e8 e9 ea eb ec ed ee ef f0 f1
c0 c1 c2 c3 c4 c5 ca cb cc cd ce cf d4 d5 d6 d7 d8 d9
c2 c3 c4 c5 c6 c7 cc cd ce cf d0 d1 d6 d7 d8 d9 da db
c4 c5 c6 c7 c8 c9 ce cf d0 d1 d2 d3 d8 d9 da db dc dd
ca cb cc cd ce cf d4 d5 d6 d7 d8 d9 de df e0 e1 e2 e3
cc cd ce cf d0 d1 d6 d7 d8 d9 da db e0 e1 e2 e3 e4 e5
ce cf d0 d1 d2 d3 d8 d9 da db dc dd e2 e3 e4 e5 e6 e7
d4 d5 d6 d7 d8 d9 de df e0 e1 e2 e3 e8 e9 ea eb ec ed
d6 d7 d8 d9 da db e0 e1 e2 e3 e4 e5 ea eb ec ed ee ef
d8 d9 da db dc dd e2 e3 e4 e5 e6 e7 ec ed ee ef f0 f1

//--- swu_top.f
swu_geom_pkg.sv
swu_stream_pkg.sv
swu_write_ctrl.sv
swu_read_ctrl.sv
swu_window_buffer.sv
swu_top.sv
tb_swu_top.sv

//--- Bender.yml
package:
  name: swu

sources:
  - swu_geom_pkg.sv
  - swu_stream_pkg.sv
  - swu_write_ctrl.sv
  - swu_read_ctrl.sv
  - swu_window_buffer.sv
  - swu_top.sv
  - target: test
    files:
      - tb_swu_top.sv
